// ==== include/axil_msi_defs.svh ====
`ifndef AXIL_MSI_DEFS_SVH
`define AXIL_MSI_DEFS_SVH

// --------------------------------------------------------------------------
// axi4-lite port widths
// --------------------------------------------------------------------------
`define AXIL_MSI_ADDR_W 40
// data width fixed at 64, event id goes in one 32-bit half
`define AXIL_MSI_DATA_W 64
`define AXIL_MSI_STRB_W 8
`define AXIL_MSI_RESP_W 2

// --------------------------------------------------------------------------
// interrupt and message fields
// --------------------------------------------------------------------------
`define AXIL_MSI_NUM_IRQ 4
`define AXIL_MSI_NUM_DEST 2
// index into the destination base table
`define AXIL_MSI_DEST_IDX_W 1
`define AXIL_MSI_DEV_ID_W 16
`define AXIL_MSI_EVT_ID_W 16
// minimum spacing counter
`define AXIL_MSI_THR_W 8

`endif

// ==== src/axil_msi_pkg.sv ====
`default_nettype none

`include "axil_msi_defs.svh"

package axil_msi_pkg;

  // bus fields
  typedef logic [`AXIL_MSI_ADDR_W-1:0] addr_t;
  typedef logic [`AXIL_MSI_DATA_W-1:0] data_t;
  typedef logic [`AXIL_MSI_STRB_W-1:0] strb_t;
  typedef logic [`AXIL_MSI_RESP_W-1:0] resp_t;

  // one bit per interrupt line
  typedef logic [`AXIL_MSI_NUM_IRQ-1:0] irq_vec_t;

  // per interrupt message config
  typedef logic [`AXIL_MSI_DEST_IDX_W-1:0] dest_idx_t;
  typedef logic [`AXIL_MSI_DEV_ID_W-1:0] dev_id_t;
  typedef logic [`AXIL_MSI_EVT_ID_W-1:0] evt_id_t;
  typedef logic [`AXIL_MSI_THR_W-1:0] thr_cnt_t;

  // axi write response codes
  localparam resp_t resp_okay = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== src/msi_irq_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module msi_irq_capture (
  input  logic                  clk,
  input  logic                  reset,
  input  axil_msi_pkg::irq_vec_t irq,
  input  axil_msi_pkg::irq_vec_t enable,
  input  axil_msi_pkg::irq_vec_t taken,
  output axil_msi_pkg::irq_vec_t pending
);

  import axil_msi_pkg::*;

  // irq_q samples the lines, irq_d is the previous sample
  irq_vec_t irq_q;
  irq_vec_t irq_d;
  irq_vec_t rise;

  // --------------------------------------------------------------------------
  // edge detect
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      irq_q <= '0;
      irq_d <= '0;
    end else begin
      irq_q <= irq;
      irq_d <= irq_q;
    end
  end

  // a line held high only rises once
  assign rise = irq_q & ~irq_d;

  // --------------------------------------------------------------------------
  // pending bits
  // --------------------------------------------------------------------------
  // set on an edge, clear when the arbiter takes it
  // a low enable masks the set and drops any pending bit
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= enable & (pending | rise) & ~taken;
    end
  end

endmodule

`default_nettype wire

// ==== src/msi_rr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_msi_defs.svh"

module msi_rr_arbiter (
  input  logic                                             clk,
  input  logic                                             reset,
  input  axil_msi_pkg::irq_vec_t                           pending,
  input  axil_msi_pkg::dest_idx_t [`AXIL_MSI_NUM_IRQ-1:0] dest_idx_per_irq,
  input  axil_msi_pkg::dev_id_t [`AXIL_MSI_NUM_IRQ-1:0]   dev_id_per_irq,
  input  axil_msi_pkg::evt_id_t [`AXIL_MSI_NUM_IRQ-1:0]   evt_id_per_irq,
  input  logic                                             sel_ready,
  output axil_msi_pkg::irq_vec_t                           taken,
  output logic                                             sel_valid,
  output axil_msi_pkg::dest_idx_t                          sel_dest_idx,
  output axil_msi_pkg::dev_id_t                            sel_dev_id,
  output axil_msi_pkg::evt_id_t                            sel_evt_id
);

  import axil_msi_pkg::*;

  localparam int num_irq = `AXIL_MSI_NUM_IRQ;
  localparam int idx_w = (num_irq > 1) ? $clog2(num_irq) : 1;

  // ptr is the line with highest priority
  logic [idx_w-1:0] ptr;
  logic [idx_w-1:0] pick_idx;
  logic [idx_w-1:0] grant_idx;
  logic [idx_w-1:0] sel_idx;
  logic [idx_w-1:0] next_ptr;
  logic             held;
  logic             any_pending;
  logic             accept;

  // --------------------------------------------------------------------------
  // round robin pick
  // --------------------------------------------------------------------------
  // first pending line at or after ptr, wrapping around
  always_comb begin : pick_blk
    int   cand;
    logic found;
    pick_idx = ptr;
    found    = 1'b0;
    for (int i = 0; i < num_irq; i++) begin
      cand = (int'(ptr) + i) % num_irq;
      if (!found && pending[cand]) begin
        found    = 1'b1;
        pick_idx = idx_w'(cand);
      end
    end
  end

  assign any_pending = |pending;

  // idle shows the live pick, a held grant shows the latched index
  assign sel_valid = held | any_pending;
  assign sel_idx   = held ? grant_idx : pick_idx;
  assign accept    = sel_valid & sel_ready;

  // taken clears the pending bit the moment the grant is made
  assign taken = (!held && any_pending) ? (irq_vec_t'(1) << pick_idx) : '0;

  // winner drops to lowest priority
  assign next_ptr = (sel_idx == idx_w'(num_irq - 1)) ? '0 : sel_idx + 1'b1;

  // --------------------------------------------------------------------------
  // grant state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= 1'b0;
      ptr  <= '0;
    end else if (accept) begin
      held <= 1'b0;
      ptr  <= next_ptr;
    end else if (!held && any_pending) begin
      held <= 1'b1;
    end
  end

  // tracks the pick while idle, frozen once held
  always_ff @(posedge clk) begin
    if (!held) begin
      grant_idx <= pick_idx;
    end
  end

  // message fields of the selected line
  assign sel_dest_idx = dest_idx_per_irq[sel_idx];
  assign sel_dev_id   = dev_id_per_irq[sel_idx];
  assign sel_evt_id   = evt_id_per_irq[sel_idx];

endmodule

`default_nettype wire

// ==== src/msi_throttle.sv ====
`timescale 1ns/1ns
`default_nettype none

module msi_throttle (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   throttle_en,
  input  axil_msi_pkg::thr_cnt_t throttle_threshold,
  input  logic                   sel_valid,
  input  logic                   sel_ready,
  output logic                   clear_to_send
);

  import axil_msi_pkg::*;

  // cycles still to wait for the message on offer
  thr_cnt_t cnt;
  logic     reload;

  // reload while idle and on every accepted message
  assign reload = ~sel_valid | sel_ready;

  // --------------------------------------------------------------------------
  // saturating down counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (reload) begin
      cnt <= throttle_threshold;
    end else if (cnt != '0) begin
      // counts down while a message waits
      cnt <= cnt - 1'b1;
    end
  end

  // throttle off lets everything through
  assign clear_to_send = ~throttle_en | (cnt == '0);

endmodule

`default_nettype wire

// ==== src/axil_skid_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_skid_reg #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_valid,
  input  logic [width-1:0] push_data,
  output logic             push_ready,
  output logic             pop_valid,
  output logic [width-1:0] pop_data,
  input  logic             pop_ready
);

  // second entry catches a push while the output is stalled
  logic             skid_valid;
  logic [width-1:0] skid_data;
  logic             push_xfer;
  logic             main_free;

  // room as long as the skid entry is empty
  assign push_ready = ~skid_valid;
  assign push_xfer  = push_valid & push_ready;

  // output entry empties or moves on this cycle
  assign main_free = ~pop_valid | pop_ready;

  // --------------------------------------------------------------------------
  // valid bits
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // skid entry is older, it goes out first
      pop_valid  <= skid_valid | push_xfer;
      skid_valid <= 1'b0;
    end else if (push_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // payload
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        pop_data <= skid_data;
      end else if (push_xfer) begin
        pop_data <= push_data;
      end
    end else if (push_xfer) begin
      skid_data <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/axil_msi.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_msi_defs.svh"

module axil_msi (
  input  logic                                             clk,
  input  logic                                             reset,
  input  axil_msi_pkg::irq_vec_t                           irq,
  input  axil_msi_pkg::irq_vec_t                           msi_enable,
  input  axil_msi_pkg::addr_t [`AXIL_MSI_NUM_DEST-1:0]     msi_dest_addr,
  input  axil_msi_pkg::dest_idx_t [`AXIL_MSI_NUM_IRQ-1:0] msi_dest_idx,
  input  axil_msi_pkg::dev_id_t [`AXIL_MSI_NUM_IRQ-1:0]   device_id_per_irq,
  input  axil_msi_pkg::evt_id_t [`AXIL_MSI_NUM_IRQ-1:0]   event_id_per_irq,
  input  logic                                             throttle_en,
  input  axil_msi_pkg::thr_cnt_t                           throttle_threshold,
  output axil_msi_pkg::addr_t                              awaddr,
  output logic                                             awvalid,
  input  logic                                             awready,
  output axil_msi_pkg::data_t                              wdata,
  output axil_msi_pkg::strb_t                              wstrb,
  output logic                                             wvalid,
  input  logic                                             wready,
  input  axil_msi_pkg::resp_t                              bresp,
  input  logic                                             bvalid,
  output logic                                             bready,
  output logic                                             error
);

  import axil_msi_pkg::*;

  localparam int half_w = `AXIL_MSI_DATA_W / 2;
  localparam int half_strb_w = `AXIL_MSI_STRB_W / 2;
  localparam int w_chan_w = `AXIL_MSI_DATA_W + `AXIL_MSI_STRB_W;

  irq_vec_t              pending;
  irq_vec_t              taken;
  logic                  sel_valid;
  logic                  sel_ready;
  dest_idx_t             sel_dest_idx;
  dev_id_t               sel_dev_id;
  evt_id_t               sel_evt_id;
  logic                  clear_to_send;
  logic                  aw_push_ready;
  logic                  w_push_ready;
  logic                  push_valid;
  addr_t                 aw_push_data;
  logic [half_w-1:0]     evt_word;
  data_t                 msg_data;
  strb_t                 msg_strb;

  // --------------------------------------------------------------------------
  // interrupt capture and selection
  // --------------------------------------------------------------------------
  msi_irq_capture u_capture (
    .clk     (clk),
    .reset   (reset),
    .irq     (irq),
    .enable  (msi_enable),
    .taken   (taken),
    .pending (pending)
  );

  msi_rr_arbiter u_arbiter (
    .clk              (clk),
    .reset            (reset),
    .pending          (pending),
    .dest_idx_per_irq (msi_dest_idx),
    .dev_id_per_irq   (device_id_per_irq),
    .evt_id_per_irq   (event_id_per_irq),
    .sel_ready        (sel_ready),
    .taken            (taken),
    .sel_valid        (sel_valid),
    .sel_dest_idx     (sel_dest_idx),
    .sel_dev_id       (sel_dev_id),
    .sel_evt_id       (sel_evt_id)
  );

  msi_throttle u_throttle (
    .clk                (clk),
    .reset              (reset),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .sel_valid          (sel_valid),
    .sel_ready          (sel_ready),
    .clear_to_send      (clear_to_send)
  );

  // both channels take the message in the same cycle or not at all
  assign sel_ready  = sel_valid & clear_to_send & aw_push_ready & w_push_ready;
  assign push_valid = sel_ready;

  // --------------------------------------------------------------------------
  // message formation
  // --------------------------------------------------------------------------
  // device id is a word offset from the chosen base
  assign aw_push_data = msi_dest_addr[sel_dest_idx] + (addr_t'(sel_dev_id) << 2);

  // event id zero padded to a 32-bit word
  assign evt_word = {{(half_w - `AXIL_MSI_EVT_ID_W){1'b0}}, sel_evt_id};

  // odd device id lands in the upper half
  always_comb begin
    if (sel_dev_id[0]) begin
      msg_data = {evt_word, {half_w{1'b0}}};
      msg_strb = {{half_strb_w{1'b1}}, {half_strb_w{1'b0}}};
    end else begin
      msg_data = {{half_w{1'b0}}, evt_word};
      msg_strb = {{half_strb_w{1'b0}}, {half_strb_w{1'b1}}};
    end
  end

  // --------------------------------------------------------------------------
  // aw and w channel registers
  // --------------------------------------------------------------------------
  axil_skid_reg #(
    .width (`AXIL_MSI_ADDR_W)
  ) u_aw_reg (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push_data  (aw_push_data),
    .push_ready (aw_push_ready),
    .pop_valid  (awvalid),
    .pop_data   (awaddr),
    .pop_ready  (awready)
  );

  axil_skid_reg #(
    .width (w_chan_w)
  ) u_w_reg (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push_data  ({msg_data, msg_strb}),
    .push_ready (w_push_ready),
    .pop_valid  (wvalid),
    .pop_data   ({wdata, wstrb}),
    .pop_ready  (wready)
  );

  // --------------------------------------------------------------------------
  // write response
  // --------------------------------------------------------------------------
  // responses are never stalled
  assign bready = 1'b1;

  // holds the status of the most recent response
  always_ff @(posedge clk) begin
    if (reset) begin
      error <= 1'b0;
    end else if (bvalid && bready) begin
      error <= (bresp != resp_okay);
    end
  end

endmodule

`default_nettype wire

// ==== tests/axil_msi_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_msi_defs.svh"

module axil_msi_tb;

  import axil_msi_pkg::*;

  localparam int num_irq = `AXIL_MSI_NUM_IRQ;

  logic                                  clk;
  logic                                  reset;
  irq_vec_t                              irq;
  irq_vec_t                              msi_enable;
  addr_t [`AXIL_MSI_NUM_DEST-1:0]        msi_dest_addr;
  dest_idx_t [`AXIL_MSI_NUM_IRQ-1:0]     msi_dest_idx;
  dev_id_t [`AXIL_MSI_NUM_IRQ-1:0]       device_id_per_irq;
  evt_id_t [`AXIL_MSI_NUM_IRQ-1:0]       event_id_per_irq;
  logic                                  throttle_en;
  thr_cnt_t                              throttle_threshold;
  addr_t                                 awaddr;
  logic                                  awvalid;
  logic                                  awready;
  data_t                                 wdata;
  strb_t                                 wstrb;
  logic                                  wvalid;
  logic                                  wready;
  resp_t                                 bresp;
  logic                                  bvalid;
  logic                                  bready;
  logic                                  error;

  // target model state
  // ready_mode 0 always ready, 1 pseudo-random, 2 held low
  int          ready_mode;
  resp_t       resp_mode;
  logic [31:0] rng_state;
  int          cycle;
  int          aw_total;
  int          w_total;
  int          b_total;
  addr_t       aw_q[$];
  int          aw_cyc_q[$];
  data_t       wd_q[$];
  strb_t       ws_q[$];

  int check_count;
  int error_count;

  axil_msi u_dut (
    .clk                (clk),
    .reset              (reset),
    .irq                (irq),
    .msi_enable         (msi_enable),
    .msi_dest_addr      (msi_dest_addr),
    .msi_dest_idx       (msi_dest_idx),
    .device_id_per_irq  (device_id_per_irq),
    .event_id_per_irq   (event_id_per_irq),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid),
    .bready             (bready),
    .error              (error)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------------------------------------------------------------
  // axi target model
  // --------------------------------------------------------------------------
  // beats are logged mid-cycle, where valid and ready are stable
  always @(negedge clk) begin
    if (reset) begin
      aw_total = 0;
      w_total  = 0;
    end else begin
      if (awvalid && awready) begin
        aw_q.push_back(awaddr);
        aw_cyc_q.push_back(cycle);
        aw_total++;
      end
      if (wvalid && wready) begin
        wd_q.push_back(wdata);
        ws_q.push_back(wstrb);
        w_total++;
      end
    end
  end

  // ready pattern and one bvalid pulse per completed address and data pair
  always @(posedge clk) begin
    case (ready_mode)
      1: begin
        rng_state = xorshift(rng_state);
        awready <= rng_state[0];
        wready  <= rng_state[7];
      end
      2: begin
        awready <= 1'b0;
        wready  <= 1'b0;
      end
      default: begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
    endcase
    if (reset) begin
      bvalid  <= 1'b0;
      b_total <= 0;
    end else if (bvalid) begin
      bvalid <= 1'b0;
    end else if (aw_total > b_total && w_total > b_total) begin
      bvalid  <= 1'b1;
      bresp   <= resp_mode;
      b_total <= b_total + 1;
    end
  end

  // --------------------------------------------------------------------------
  // expected message per line
  // --------------------------------------------------------------------------
  // base of the chosen destination plus a word offset of the device id
  function automatic addr_t predict_addr(input int idx);
    return msi_dest_addr[msi_dest_idx[idx]] + addr_t'(device_id_per_irq[idx]) * 4;
  endfunction

  // odd device id puts the event id in bits 63:32
  function automatic data_t predict_data(input int idx);
    if (device_id_per_irq[idx][0]) begin
      return data_t'(event_id_per_irq[idx]) << 32;
    end else begin
      return data_t'(event_id_per_irq[idx]);
    end
  endfunction

  function automatic strb_t predict_strb(input int idx);
    return device_id_per_irq[idx][0] ? 8'hf0 : 8'h0f;
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // pops the oldest address and data beat and checks them against line idx
  task automatic check_msg(input int idx);
    if (aw_q.size() == 0 || wd_q.size() == 0) begin
      error_count++;
      $display("no beat left to match the message of line %0d", idx);
    end else begin
      void'(aw_cyc_q.pop_front());
      check_addr($sformatf("awaddr line %0d", idx), aw_q.pop_front(), predict_addr(idx));
      check_data($sformatf("wdata line %0d", idx), wd_q.pop_front(), predict_data(idx));
      check_strb($sformatf("wstrb line %0d", idx), ws_q.pop_front(), predict_strb(idx));
    end
  endtask

  // --------------------------------------------------------------------------
  // sequencing helpers
  // --------------------------------------------------------------------------
  task automatic timeout_abort(input string what);
    $display("timeout at t=%0t while waiting for %s", $time, what);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset              <= 1'b1;
    irq                <= '0;
    msi_enable         <= '1;
    throttle_en        <= 1'b0;
    throttle_threshold <= '0;
    ready_mode         <= 0;
    resp_mode          <= resp_okay;
    repeat (16) @(posedge clk);
    aw_q.delete();
    aw_cyc_q.delete();
    wd_q.delete();
    ws_q.delete();
    reset <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic raise_lines(input irq_vec_t mask);
    @(posedge clk);
    irq <= irq | mask;
  endtask

  task automatic drop_lines(input irq_vec_t mask);
    @(posedge clk);
    irq <= irq & ~mask;
  endtask

  task automatic wait_beats(input int n, input int limit);
    int waited;
    waited = 0;
    while ((aw_q.size() < n || wd_q.size() < n) && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (aw_q.size() < n || wd_q.size() < n) begin
      timeout_abort($sformatf("%0d address and data beats", n));
    end
  endtask

  task automatic wait_responses(input int n, input int limit);
    int waited;
    waited = 0;
    while (b_total < n && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (b_total < n) begin
      timeout_abort($sformatf("%0d write responses", n));
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_single();
    int errs;
    int lat;
    errs = error_count;
    apply_reset();
    check_bit("awvalid after reset", awvalid, 1'b0);
    check_bit("wvalid after reset", wvalid, 1'b0);
    check_bit("error after reset", error, 1'b0);
    check_bit("bready after reset", bready, 1'b1);
    // edge sampled one clock after the drive, awvalid up after two more,
    // seen by this loop on the edge after that
    raise_lines(4'b0001);
    lat = 0;
    while (!awvalid && lat < 20) begin
      @(posedge clk);
      lat++;
    end
    if (!awvalid) begin
      timeout_abort("awvalid of the first message");
    end
    check_bit($sformatf("awvalid latency %0d cycles is 4", lat), lat == 4, 1'b1);
    wait_beats(1, 50);
    check_msg(0);
    raise_lines(4'b0010);
    wait_beats(1, 50);
    check_msg(1);
    drop_lines(4'b0011);
    finish_test("single_message", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = error_count;
    apply_reset();
    ready_mode <= 1;
    raise_lines(4'b1111);
    wait_beats(4, 400);
    // round robin from line zero after reset
    for (int i = 0; i < num_irq; i++) begin
      check_msg(i);
    end
    idle(30);
    check_bit("no extra address beat", aw_total == 4, 1'b1);
    check_bit("no extra data beat", w_total == 4, 1'b1);
    drop_lines(4'b1111);
    finish_test("backpressure", errs);
  endtask

  task automatic test_masking();
    int errs;
    errs = error_count;
    apply_reset();
    msi_enable <= 4'b1011;
    raise_lines(4'b0100);
    idle(50);
    check_bit("masked line sends nothing", aw_total == 0, 1'b1);
    // stall the bus, lines 0 and 1 fill the channel registers,
    // line 2 is held by the arbiter and line 3 stays pending
    apply_reset();
    ready_mode <= 2;
    raise_lines(4'b1111);
    idle(12);
    check_bit("nothing sent while stalled", aw_total == 0, 1'b1);
    @(posedge clk);
    msi_enable <= 4'b0111;
    idle(3);
    ready_mode <= 0;
    wait_beats(3, 100);
    for (int i = 0; i < 3; i++) begin
      check_msg(i);
    end
    idle(30);
    check_bit("disabled pending line dropped", aw_total == 3, 1'b1);
    drop_lines(4'b1111);
    finish_test("enable_masking", errs);
  endtask

  task automatic test_level();
    int errs;
    errs = error_count;
    apply_reset();
    raise_lines(4'b0001);
    idle(40);
    check_bit("one message during hold", aw_total == 1, 1'b1);
    check_msg(0);
    drop_lines(4'b0001);
    idle(4);
    raise_lines(4'b0001);
    wait_beats(1, 50);
    check_msg(0);
    check_bit("second message after re-edge", aw_total == 2, 1'b1);
    drop_lines(4'b0001);
    finish_test("level_and_reedge", errs);
  endtask

  task automatic test_throttle();
    int errs;
    int gap;
    errs = error_count;
    apply_reset();
    throttle_en        <= 1'b1;
    throttle_threshold <= 8'd6;
    raise_lines(4'b0111);
    wait_beats(3, 200);
    for (int i = 0; i < 2; i++) begin
      gap = aw_cyc_q[i + 1] - aw_cyc_q[i];
      check_bit($sformatf("throttled gap %0d at least 6", gap), gap >= 6, 1'b1);
    end
    for (int i = 0; i < 3; i++) begin
      check_msg(i);
    end
    drop_lines(4'b0111);
    @(posedge clk);
    throttle_en <= 1'b0;
    idle(5);
    // pointer sits on line 3, which is not raised, so 0, 1 and 2 follow
    raise_lines(4'b0111);
    wait_beats(3, 100);
    for (int i = 0; i < 2; i++) begin
      gap = aw_cyc_q[i + 1] - aw_cyc_q[i];
      check_bit($sformatf("unthrottled gap %0d is 1", gap), gap == 1, 1'b1);
    end
    for (int i = 0; i < 3; i++) begin
      check_msg(i);
    end
    drop_lines(4'b0111);
    finish_test("throttle", errs);
  endtask

  task automatic test_error();
    int errs;
    errs = error_count;
    apply_reset();
    resp_mode <= resp_slverr;
    raise_lines(4'b0001);
    wait_responses(1, 100);
    idle(2);
    check_bit("error after slverr", error, 1'b1);
    check_bit("bready after slverr", bready, 1'b1);
    @(posedge clk);
    resp_mode <= resp_okay;
    raise_lines(4'b0010);
    wait_responses(2, 100);
    idle(2);
    check_bit("error after okay", error, 1'b0);
    check_msg(0);
    check_msg(1);
    drop_lines(4'b0011);
    finish_test("error_flag", errs);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    clk                = 1'b0;
    reset              = 1'b1;
    irq                = '0;
    msi_enable         = '1;
    throttle_en        = 1'b0;
    throttle_threshold = '0;
    awready            = 1'b1;
    wready             = 1'b1;
    bresp              = resp_okay;
    bvalid             = 1'b0;
    ready_mode         = 0;
    resp_mode          = resp_okay;
    rng_state          = 32'd61;
    cycle              = 0;
    b_total            = 0;
    check_count        = 0;
    error_count        = 0;
    // two destinations, lines alternate between them and between halves
    msi_dest_addr[0]     = 40'h00_fee0_0000;
    msi_dest_addr[1]     = 40'h12_3400_1000;
    msi_dest_idx         = 4'b1010;
    device_id_per_irq[0] = 16'h0010;
    device_id_per_irq[1] = 16'h0023;
    device_id_per_irq[2] = 16'h0102;
    device_id_per_irq[3] = 16'h0455;
    event_id_per_irq[0]  = 16'h1001;
    event_id_per_irq[1]  = 16'h2002;
    event_id_per_irq[2]  = 16'h3003;
    event_id_per_irq[3]  = 16'h4004;

    test_single();
    test_backpressure();
    test_masking();
    test_level();
    test_throttle();
    test_error();

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== axil_msi.f ====
+incdir+include
src/axil_msi_pkg.sv
src/msi_irq_capture.sv
src/msi_rr_arbiter.sv
src/msi_throttle.sv
src/axil_skid_reg.sv
src/axil_msi.sv
tests/axil_msi_tb.sv

// ==== Makefile ====
# Verilator simulation of the axil_msi testbench

VERILATOR ?= verilator
TOP       ?= axil_msi_tb
FILELIST  ?= axil_msi.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= >>> FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
